//--- Bender.yml
package:
  name: mul_exec

sources:
  # Packages first, then the blocks bottom up
  - common/mul_config_pkg.sv
  - common/mul_isa_pkg.sv
  - rtl/mul_issue.sv
  - mul/mul_unit.sv
  - rtl/mul_writeback.sv
  - rtl/mul_exec_top.sv
  - target: test
    files:
      - testbench/mul_exec_tb.sv

//--- common/mul_config_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Sizing constants for the multiply execution slice
// Imported by the RTL modules and the testbench
////////////////////////////////////////////////////////////////////////////

package mul_config_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data path

    // One RV32 register
    localparam int XLEN = 32;

    // Register number, x0..x31
    localparam int REG_ADDR_W = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Id pool

    // Pool size, the top passes it down as MAX_INFLIGHT
    // At least 4 so the rotating ids never run dry at one issue per cycle
    localparam int DEFAULT_MAX_INFLIGHT = 4;

endpackage

//--- common/mul_isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// RV32M encodings and the instruction word views
// Raw word and R-type fields share one union, decoded by the issue stage
////////////////////////////////////////////////////////////////////////////

package mul_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode and funct7

    localparam logic [6:0] OPCODE_OP     = 7'b0110011; // Reg-reg ALU ops
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // M extension marker

    ////////////////////////////////////////////////////////////////////////////
    // funct3 codes of the multiply group

    localparam logic [2:0] MUL_FN3    = 3'b000;
    localparam logic [2:0] MULH_FN3   = 3'b001;
    localparam logic [2:0] MULHSU_FN3 = 3'b010;
    localparam logic [2:0] MULHU_FN3  = 3'b011;
    // DIV/DIVU/REM/REMU sit at 4..7, not handled here

    // Multiply kind, same order as funct3[1:0]
    typedef enum logic [1:0] {
        OP_MUL    = 2'b00, // Low half
        OP_MULH   = 2'b01, // High half, signed x signed
        OP_MULHSU = 2'b10, // High half, signed x unsigned
        OP_MULHU  = 2'b11  // High half, unsigned x unsigned
    } mul_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word

    // R-type layout, msb first
    typedef struct packed {
        logic [6:0] funct7; // [31:25]
        logic [4:0] rs2;    // [24:20]
        logic [4:0] rs1;    // [19:15]
        logic [2:0] funct3; // [14:12]
        logic [4:0] rd;     // [11:7]
        logic [6:0] opcode; // [6:0]
    } rtype_fields_t;

    // Same 32 bits, read as a raw word or as fields
    typedef union packed {
        logic [31:0]   raw;
        rtype_fields_t fields;
    } instr_word_u;

endpackage

//--- mul/mul_unit.sv
////////////////////////////////////////////////////////////////////////////
// Pipelined 33x33 signed multiply with a result bank indexed by id
// Operands and product are registered and the bank is read by writeback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_unit
    import mul_config_pkg::*;
    import mul_isa_pkg::*;
#(
    parameter int  MAX_INFLIGHT = DEFAULT_MAX_INFLIGHT,
    localparam int ID_W         = $clog2(MAX_INFLIGHT)
) (
    input  logic                    clk,
    input  logic                    reset,

    // Issue side
    input  logic                    new_request,
    input  mul_op_e                 op,
    input  logic [XLEN-1:0]         rs1_data,
    input  logic [XLEN-1:0]         rs2_data,
    input  logic [ID_W-1:0]         instruction_id,
    input  logic [MAX_INFLIGHT-1:0] instruction_id_one_hot,

    // Writeback side
    input  logic [ID_W-1:0]         wb_id,
    output logic [MAX_INFLIGHT-1:0] done_next_cycle,
    output logic [XLEN-1:0]         wb_rd
);

    logic                    rs1_signed;
    logic                    rs2_signed;
    logic signed [XLEN:0]    rs1_ext;
    logic signed [XLEN:0]    rs2_ext;
    logic signed [XLEN:0]    rs1_r;
    logic signed [XLEN:0]    rs2_r;
    logic signed [2*XLEN+1:0] product;

    // Control pipeline with index 1 lined up with product
    logic                    mulh [1:0];
    logic [ID_W-1:0]         id   [1:0];
    logic [MAX_INFLIGHT-1:0] id_one_hot_done [1:0];

    logic [XLEN-1:0]         rd_bank [MAX_INFLIGHT-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Operand extension

    // rs1 signed for MULH and MULHSU
    // rs2 signed only for MULH
    // MUL keeps the same low half either way
    assign rs1_signed = op inside {OP_MULH, OP_MULHSU};
    assign rs2_signed = (op == OP_MULH);

    assign rs1_ext = {rs1_data[XLEN-1] & rs1_signed, rs1_data};
    assign rs2_ext = {rs2_data[XLEN-1] & rs2_signed, rs2_data};

    // Input and output registered multiply
    always_ff @(posedge clk) begin
        rs1_r   <= rs1_ext;       // End of issue cycle
        rs2_r   <= rs2_ext;
        product <= rs1_r * rs2_r; // End of next cycle
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control following the data

    always_ff @(posedge clk) begin
        mulh[0] <= (op != OP_MUL);
        mulh[1] <= mulh[0];
        id[0]   <= instruction_id;
        id[1]   <= id[0];
    end

    // Done bits carry the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            id_one_hot_done[0] <= '0;
            id_one_hot_done[1] <= '0;
        end else begin
            id_one_hot_done[0] <= instruction_id_one_hot & {MAX_INFLIGHT{new_request}};
            id_one_hot_done[1] <= id_one_hot_done[0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result bank

    always_ff @(posedge clk) begin
        if (|id_one_hot_done[1]) begin
            rd_bank[id[1]] <= mulh[1] ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
        end
    end

    assign done_next_cycle = id_one_hot_done[1]; // Bank written on the coming edge
    assign wb_rd           = rd_bank[wb_id];

endmodule

//--- mul_exec.f
common/mul_config_pkg.sv
common/mul_isa_pkg.sv
rtl/mul_issue.sv
mul/mul_unit.sv
rtl/mul_writeback.sv
rtl/mul_exec_top.sv
testbench/mul_exec_tb.sv

//--- rtl/mul_exec_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the multiply execution slice
// Issue, multiply unit and writeback, result 3 cycles after issue
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_exec_top
    import mul_config_pkg::*;
    import mul_isa_pkg::*;
#(
    parameter int  MAX_INFLIGHT = DEFAULT_MAX_INFLIGHT,
    localparam int ID_W         = $clog2(MAX_INFLIGHT)
) (
    input  logic                  clk,
    input  logic                  reset,

    // One R-type word per cycle with its operands
    input  logic                  instr_valid,
    input  instr_word_u           instr,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,

    // Retire strobe
    output logic                  result_valid,
    output logic [REG_ADDR_W-1:0] result_rd,
    output logic [XLEN-1:0]       result_data,

    output logic                  illegal_valid
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wiring

    logic                    new_request;
    mul_op_e                 op;
    logic [ID_W-1:0]         instruction_id;
    logic [MAX_INFLIGHT-1:0] instruction_id_one_hot;
    logic [REG_ADDR_W-1:0]   issue_rd;
    logic [MAX_INFLIGHT-1:0] done_next_cycle;
    logic [ID_W-1:0]         wb_id;
    logic [XLEN-1:0]         wb_rd;

    // Decode and id allocation
    mul_issue #(
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) i_issue (
        .clk                    (clk),
        .reset                  (reset),
        .instr_valid            (instr_valid),
        .instr                  (instr),
        .new_request            (new_request),
        .op                     (op),
        .instruction_id         (instruction_id),
        .instruction_id_one_hot (instruction_id_one_hot),
        .issue_rd               (issue_rd),
        .illegal_valid          (illegal_valid)
    );

    // Operands pass straight through to the multiplier
    mul_unit #(
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) i_mul_unit (
        .clk                    (clk),
        .reset                  (reset),
        .new_request            (new_request),
        .op                     (op),
        .rs1_data               (rs1_data),
        .rs2_data               (rs2_data),
        .instruction_id         (instruction_id),
        .instruction_id_one_hot (instruction_id_one_hot),
        .wb_id                  (wb_id),
        .done_next_cycle        (done_next_cycle),
        .wb_rd                  (wb_rd)
    );

    mul_writeback #(
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) i_writeback (
        .clk             (clk),
        .reset           (reset),
        .new_request     (new_request),
        .instruction_id  (instruction_id),
        .issue_rd        (issue_rd),
        .done_next_cycle (done_next_cycle),
        .wb_rd           (wb_rd),
        .wb_id           (wb_id),
        .result_valid    (result_valid),
        .result_rd       (result_rd),
        .result_data     (result_data)
    );

endmodule

//--- rtl/mul_issue.sv
////////////////////////////////////////////////////////////////////////////
// Issue stage of the multiply slice
// Decodes one word per cycle, rejects non-multiply words, hands out ids
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_issue
    import mul_config_pkg::*;
    import mul_isa_pkg::*;
#(
    parameter int  MAX_INFLIGHT = DEFAULT_MAX_INFLIGHT,
    localparam int ID_W         = $clog2(MAX_INFLIGHT)
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    instr_valid,
    input  instr_word_u             instr,

    output logic                    new_request,            // Same cycle as instr_valid
    output mul_op_e                 op,
    output logic [ID_W-1:0]         instruction_id,
    output logic [MAX_INFLIGHT-1:0] instruction_id_one_hot,
    output logic [REG_ADDR_W-1:0]   issue_rd,

    output logic                    illegal_valid           // One cycle after the word
);

    logic            opcode_ok;
    logic            funct7_ok;
    logic            funct3_ok;
    logic            is_mul;
    logic [ID_W-1:0] id_count; // Next id to hand out

    ////////////////////////////////////////////////////////////////////////////
    // Decode through the field view

    assign opcode_ok = (instr.fields.opcode == OPCODE_OP);
    assign funct7_ok = (instr.fields.funct7 == FUNCT7_MULDIV);
    // Divide/remainder codes fall outside this set
    assign funct3_ok = instr.fields.funct3 inside {MUL_FN3, MULH_FN3, MULHSU_FN3, MULHU_FN3};
    assign is_mul    = opcode_ok & funct7_ok & funct3_ok;

    always_comb begin
        case (instr.fields.funct3)
            MULH_FN3:   op = OP_MULH;
            MULHSU_FN3: op = OP_MULHSU;
            MULHU_FN3:  op = OP_MULHU;
            default:    op = OP_MUL;   // MUL, and don't care when illegal
        endcase
    end

    assign new_request = instr_valid & is_mul;
    assign issue_rd    = instr.fields.rd;

    ////////////////////////////////////////////////////////////////////////////
    // Rotating id pool

    always_ff @(posedge clk) begin
        if (reset) begin
            id_count <= '0;
        end else if (new_request) begin
            // Wrap after the last id
            if (id_count == ID_W'(MAX_INFLIGHT - 1)) begin
                id_count <= '0;
            end else begin
                id_count <= id_count + 1'b1;
            end
        end
    end

    assign instruction_id         = id_count;
    assign instruction_id_one_hot = MAX_INFLIGHT'(1) << id_count;

    ////////////////////////////////////////////////////////////////////////////
    // Illegal strobe

    always_ff @(posedge clk) begin
        if (reset) begin
            illegal_valid <= 1'b0;
        end else begin
            illegal_valid <= instr_valid & ~is_mul; // Nothing goes downstream
        end
    end

endmodule

//--- rtl/mul_writeback.sv
////////////////////////////////////////////////////////////////////////////
// Writeback stage of the multiply slice
// Keeps rd per id, reads the result bank and emits the retire strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_writeback
    import mul_config_pkg::*;
#(
    parameter int  MAX_INFLIGHT = DEFAULT_MAX_INFLIGHT,
    localparam int ID_W         = $clog2(MAX_INFLIGHT)
) (
    input  logic                    clk,
    input  logic                    reset,

    // From issue
    input  logic                    new_request,
    input  logic [ID_W-1:0]         instruction_id,
    input  logic [REG_ADDR_W-1:0]   issue_rd,

    // From and to the multiply unit
    input  logic [MAX_INFLIGHT-1:0] done_next_cycle,
    input  logic [XLEN-1:0]         wb_rd,
    output logic [ID_W-1:0]         wb_id,

    // Retire strobe
    output logic                    result_valid,
    output logic [REG_ADDR_W-1:0]   result_rd,
    output logic [XLEN-1:0]         result_data
);

    logic [REG_ADDR_W-1:0] rd_table [MAX_INFLIGHT-1:0]; // Destination per id
    logic [ID_W-1:0]       done_id;
    logic [ID_W-1:0]       done_id_r;

    ////////////////////////////////////////////////////////////////////////////
    // Destination table

    always_ff @(posedge clk) begin
        if (new_request) begin
            rd_table[instruction_id] <= issue_rd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Done id

    // One-hot to binary, at most one bit set
    always_comb begin
        done_id = '0;
        for (int i = 0; i < MAX_INFLIGHT; i++) begin
            if (done_next_cycle[i]) begin
                done_id = ID_W'(i);
            end
        end
    end

    // Same edge as the bank write
    always_ff @(posedge clk) begin
        done_id_r <= done_id;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= |done_next_cycle;
        end
    end

    assign wb_id       = done_id_r;
    assign result_data = wb_rd;               // Bank word for this id
    assign result_rd   = rd_table[done_id_r];

endmodule

//--- testbench/mul_exec_golden.txt
// word     rs1      rs2      kind rd data
// kind R is a retired result, I an illegal word whose rd and data are unused
022080B3 00000007 00000006 R 01 0000002A
02208133 FFFFFFFD 00000005 R 02 FFFFFFF1
022081B3 80000000 00000002 R 03 00000000
02208233 FFFFFFFF FFFFFFFF R 04 00000001
02208093 00000003 00000004 I 00 00000000
022082B3 12345678 00000010 R 05 23456780
02209333 80000000 80000000 R 06 40000000
022093B3 FFFFFFFF 00000005 R 07 FFFFFFFF
0220C1B3 00000064 00000007 I 00 00000000
02209433 7FFFFFFF 7FFFFFFF R 08 3FFFFFFF
022094B3 80000000 00000001 R 09 FFFFFFFF
0220A533 FFFFFFFF FFFFFFFF R 0A FFFFFFFF
00208133 00000001 00000002 I 00 00000000
0220A5B3 80000000 80000000 R 0B C0000000
0220A633 00000002 FFFFFFFF R 0C 00000001
0220D233 00000064 00000007 I 00 00000000
0220A6B3 7FFFFFFF 80000000 R 0D 3FFFFFFF
0220B733 FFFFFFFF FFFFFFFF R 0E FFFFFFFE
0220B7B3 80000000 80000000 R 0F 40000000
0220E2B3 FFFFFFFF 00000003 I 00 00000000
0220B833 80000000 00000002 R 10 00000001
0220B8B3 12345678 00010000 R 11 00001234
0220F333 80000000 FFFFFFFF I 00 00000000
40208133 00000009 00000004 I 00 00000000
02208FB3 FFFFFFFF 00000002 R 1F FFFFFFFE
0220BA33 DEADBEEF 00000010 R 14 0000000D
02209AB3 FFFF0000 FFFF0000 R 15 00000001
02208033 0000FFFF 0000FFFF R 00 FFFE0001

//--- testbench/mul_exec_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the multiply execution slice
// Replays the golden file and checks data, destination and latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_exec_tb
    import mul_config_pkg::*;
    import mul_isa_pkg::*;
();

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  instr_valid;
    instr_word_u           instr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  result_valid;
    logic [REG_ADDR_W-1:0] result_rd;
    logic [XLEN-1:0]       result_data;
    logic                  illegal_valid;

    int cycle   = 0; // Counts clock edges
    int errors  = 0;
    int checked = 0;

    // Golden entries in file order
    logic [31:0]           gold_word [$];
    logic [XLEN-1:0]       gold_rs1  [$];
    logic [XLEN-1:0]       gold_rs2  [$];
    logic [7:0]            gold_kind [$]; // "R" or "I"
    logic [REG_ADDR_W-1:0] gold_rd   [$];
    logic [XLEN-1:0]       gold_data [$];

    // Outstanding strobes oldest first by entry index and issue cycle
    int exp_res_idx [$];
    int exp_res_cyc [$];
    int exp_ill_idx [$];
    int exp_ill_cyc [$];

    always #10 clk = ~clk; // 20 ns period

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    mul_exec_top #(
        .MAX_INFLIGHT (DEFAULT_MAX_INFLIGHT)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .result_valid  (result_valid),
        .result_rd     (result_rd),
        .result_data   (result_data),
        .illegal_valid (illegal_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Golden file and stimulus

    task automatic load_golden();
        int               fd;
        int               n;
        logic [8*128-1:0] text;
        logic [31:0]      word;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [7:0]       kind;
        logic [4:0]       rd;
        logic [XLEN-1:0]  data;
        fd = $fopen("testbench/mul_exec_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file testbench/mul_exec_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                text = '0;
                n    = $fgets(text, fd);
                // Comment and blank lines scan fewer than six fields
                if (n > 0 && $sscanf(text, "%h %h %h %c %h %h",
                                     word, a, b, kind, rd, data) == 6) begin
                    gold_word.push_back(word);
                    gold_rs1.push_back(a);
                    gold_rs2.push_back(b);
                    gold_kind.push_back(kind);
                    gold_rd.push_back(rd);
                    gold_data.push_back(data);
                end
            end
            $fclose(fd);
        end
    endtask

    // Drives one word for the coming cycle and books its expected strobe
    task automatic drive_entry(input int i);
        instr_valid <= 1'b1;
        instr.raw   <= gold_word[i];
        rs1_data    <= gold_rs1[i];
        rs2_data    <= gold_rs2[i];
        if (gold_kind[i] == "R") begin
            exp_res_idx.push_back(i);
            exp_res_cyc.push_back(cycle + 1); // Issue cycle starts at this edge
        end else begin
            exp_ill_idx.push_back(i);
            exp_ill_cyc.push_back(cycle + 1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitor sampled mid cycle

    task automatic check_result();
        int idx;
        int issued;
        int errs_before;
        errs_before = errors;
        assert (exp_res_idx.size() != 0) else begin
            $display("Result strobe at %0t ns with no multiply waiting for it", $time);
            errors++;
        end
        if (exp_res_idx.size() != 0) begin
            idx    = exp_res_idx.pop_front();
            issued = exp_res_cyc.pop_front();
            assert (result_rd == gold_rd[idx]) else begin
                $display("Fail at %0t ns: entry %0d result_rd %0d, expected %0d",
                         $time, idx, result_rd, gold_rd[idx]);
                errors++;
            end
            assert (result_data == gold_data[idx]) else begin
                $display("Fail at %0t ns: entry %0d result_data %h, expected %h",
                         $time, idx, result_data, gold_data[idx]);
                errors++;
            end
            assert (cycle == issued + 3) else begin // Fixed 3 cycle latency
                $display("Fail at %0t ns: entry %0d result in cycle %0d, issued in %0d",
                         $time, idx, cycle, issued);
                errors++;
            end
            checked++;
            $display("Entry %0d result x%0d = %h %s", idx, gold_rd[idx], gold_data[idx],
                     (errors == errs_before) ? "ok" : "wrong");
        end
    endtask

    task automatic check_illegal();
        int idx;
        int issued;
        int errs_before;
        errs_before = errors;
        assert (exp_ill_idx.size() != 0) else begin
            $display("Illegal strobe at %0t ns with no illegal word waiting for it", $time);
            errors++;
        end
        if (exp_ill_idx.size() != 0) begin
            idx    = exp_ill_idx.pop_front();
            issued = exp_ill_cyc.pop_front();
            assert (cycle == issued + 1) else begin
                $display("Fail at %0t ns: entry %0d illegal strobe in cycle %0d, issued in %0d",
                         $time, idx, cycle, issued);
                errors++;
            end
            checked++;
            $display("Entry %0d illegal word %h %s", idx, gold_word[idx],
                     (errors == errs_before) ? "ok" : "wrong");
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (result_valid) check_result();
            if (illegal_valid) check_illegal();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int run_left;
        int gap;
        int wait_cycles;
        void'($urandom(92));
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        load_golden();
        if (gold_word.size() == 0) begin
            $display("No golden entries were read, nothing to check");
            $display("Finished with errors");
        end else begin
            repeat (2) @(posedge clk);
            reset <= 1'b0;
            run_left = 8; // Opening burst wraps the id pool twice
            for (int i = 0; i < gold_word.size(); i++) begin
                if (run_left > 0) begin
                    run_left--;
                    gap = 0;
                end else begin
                    gap = $urandom % 3;
                    if (gap == 0) run_left = 5 + $urandom % 3; // Next back-to-back run
                end
                repeat (gap) begin
                    @(posedge clk);
                    instr_valid <= 1'b0;
                end
                @(posedge clk);
                drive_entry(i);
            end
            @(posedge clk);
            instr_valid <= 1'b0;
            // Bounded drain
            wait_cycles = 0;
            while ((exp_res_idx.size() != 0 || exp_ill_idx.size() != 0) && wait_cycles < 50) begin
                @(posedge clk);
                wait_cycles++;
            end
            if (exp_res_idx.size() != 0 || exp_ill_idx.size() != 0) begin
                $display("Timed out with %0d results and %0d illegal strobes missing",
                         exp_res_idx.size(), exp_ill_idx.size());
                $display("Finished with errors");
            end else begin
                repeat (4) @(posedge clk); // Room for stray strobes
                $display("Checked %0d of %0d entries, %0d errors",
                         checked, gold_word.size(), errors);
                if (errors == 0) begin
                    $display("Finished with no errors");
                end else begin
                    $display("Finished with errors");
                end
            end
        end
        $finish;
    end

endmodule
